//--- design/gate_drive.sv
`timescale 1ns/1ns
`default_nettype none

module gate_drive (
   input  logic                              clk,
   input  logic                              rst_n,
   input  pulse_pkg::seq_mode_e              mode,
   input  logic [pulse_pkg::time_w-1:0]      counter,
   input  logic [pulse_pkg::time_w-1:0]      period,
   input  logic                              in_excite,
   input  logic                              in_refocus,
   input  logic                              in_window,
   input  logic                              train_active,
   input  logic [pulse_pkg::time_w-1:0]      first_ref_start,
   input  logic [pulse_pkg::time_w-1:0]      sdown,
   input  logic [pulse_pkg::time_w-1:0]      nut_start,
   input  logic [pulse_pkg::time_w-1:0]      nut_stop,
   input  logic [pulse_pkg::att_w-1:0]       pr_att,
   input  logic                              bl,
   input  logic [2:0]                        phsub,
   output logic                              sync_on,
   output logic                              pulse1_on,
   output logic                              pulse2_on,
   output logic [pulse_pkg::att_w-1:0]       pre_att,
   output logic                              pre_block,
   output logic                              phase90,
   output logic                              phase180,
   output logic                              inhib
);

   import pulse_pkg::*;

   logic             nut_on;   // auxiliary nutation pulse region
   logic             tail;     // last tail_len cycles of the frame
   logic             mid;      // phase-shifted region around the train
   logic             ph_en;
   logic [att_w-1:0] att_hi;

   assign nut_on = (counter >= nut_start) && (counter < nut_stop);
   assign tail   = (counter + time_w'(tail_len) >= period);
   // written without subtraction so short settings cannot wrap
   assign mid    = (counter + time_w'(phase_lead) >= first_ref_start) && !tail;
   assign ph_en  = (phsub != 3'd0);
   assign att_hi = pr_att + att_w'(att_step);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sync_on   <= 1'b0;
         pulse1_on <= 1'b0;
         pulse2_on <= 1'b0;
         pre_att   <= '0;
         pre_block <= 1'b0;
         phase90   <= 1'b0;
         phase180  <= 1'b0;
         inhib     <= 1'b0;
      end else if (mode == mode_cw) begin
         // CW, both switches follow bl and the receiver stays open
         pulse1_on <= !bl;
         pulse2_on <= bl;
         inhib     <= 1'b0;
         pre_block <= 1'b1;
         pre_att   <= pr_att;
         sync_on   <= (counter >= sdown);   // scope trigger
         phase90   <= phsub[1];
         phase180  <= phsub[2];
      end else begin
         pulse1_on <= in_excite || in_refocus;
         pulse2_on <= nut_on;
         inhib     <= bl && !in_window;     // open only for the echo
         pre_block <= pulse1_on || pulse2_on;   // one cycle behind the switches
         sync_on   <= train_active;
         pre_att   <= (in_excite || tail) ? att_hi : pr_att;
         if (ph_en) begin
            phase90  <= mid;
            phase180 <= mid ? phsub[2] : (phsub[2] ^ phsub[1]);
         end else begin
            phase90  <= 1'b0;
            phase180 <= 1'b0;
         end
      end
   end

   // with blanking on, the receiver never opens while the transmitter is on
   a_tx_rx : assert property (@(posedge clk) disable iff (!rst_n)
                              (mode != mode_cw && bl) |=> !(pulse1_on && !inhib));

endmodule

`default_nettype wire

//--- design/pulse_pkg.sv
`default_nettype none

package pulse_pkg;

   // datapath widths
   localparam int time_w  = 32;   // frame counter and period
   localparam int short_w = 16;   // widths, delays, blanking offsets
   localparam int att_w   = 7;    // attenuator word
   localparam int count_w = 8;    // refocusing pulse count

   // fixed timing constants, all in clk cycles
   localparam int att_step    = 6;    // extra attenuation on excitation and tail
   localparam int tail_len    = 20;   // tail region before frame end
   localparam int phase_lead  = 20;   // phase switches this early before first pi pulse
   localparam int window_trim = 5;    // echo window closes this early

   // sequence mode, decoded from the refocusing count
   typedef enum logic [1:0] {
      mode_cw,     // count 0, switches held open
      mode_hahn,   // count 1, single echo
      mode_cpmg    // count above 1, echo train
   } seq_mode_e;

   // pulse train position inside a frame
   typedef enum logic [1:0] {
      st_excite,   // before the first refocusing pulse
      st_free,     // after a pulse end, echo window and gap
      st_refocus,  // current pulse pending or on
      st_done      // train finished, wait for frame end
   } train_state_e;

endpackage

`default_nettype wire

//--- design/pulse_seq_top.sv
`timescale 1ns/1ns
`default_nettype none

module pulse_seq_top (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [pulse_pkg::time_w-1:0]      per,
   input  logic [pulse_pkg::short_w-1:0]     p1wid,
   input  logic [pulse_pkg::short_w-1:0]     del,
   input  logic [pulse_pkg::short_w-1:0]     p2wid,
   input  logic [pulse_pkg::short_w-1:0]     nut_w,
   input  logic [pulse_pkg::short_w-1:0]     nut_d,
   input  logic [pulse_pkg::att_w-1:0]       pr_att,
   input  logic [pulse_pkg::count_w-1:0]     cp,
   input  logic [pulse_pkg::short_w-1:0]     p_bl,
   input  logic                              bl,
   input  logic [2:0]                        phsub,
   output logic                              sync_on,
   output logic                              pulse1_on,
   output logic                              pulse2_on,
   output logic [pulse_pkg::att_w-1:0]       pre_att,
   output logic                              pre_block,
   output logic                              phase90,
   output logic                              phase180,
   output logic                              inhib
);

   import pulse_pkg::*;

   seq_mode_e          mode;
   logic [time_w-1:0]  period;
   logic [short_w-1:0] sh_p1wid;
   logic [short_w-1:0] sh_del;
   logic [short_w-1:0] sh_p2wid;
   logic [att_w-1:0]   sh_pr_att;
   logic [count_w-1:0] sh_cp;
   logic [short_w-1:0] sh_p_bl;
   logic               sh_bl;
   logic [2:0]         sh_phsub;
   logic [time_w-1:0]  sdown;
   logic [time_w-1:0]  nut_start;
   logic [time_w-1:0]  nut_stop;
   logic [time_w-1:0]  counter;
   logic               frame_end;
   logic               in_excite;
   logic               in_refocus;
   logic               in_window;
   logic               train_active;
   logic [time_w-1:0]  first_ref_start;

   // decode, settings shadowed per frame
   seq_config seq_config_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .frame_end (frame_end),
      .per       (per),
      .p1wid     (p1wid),
      .del       (del),
      .p2wid     (p2wid),
      .nut_w     (nut_w),
      .nut_d     (nut_d),
      .pr_att    (pr_att),
      .cp        (cp),
      .p_bl      (p_bl),
      .bl        (bl),
      .phsub     (phsub),
      .mode      (mode),
      .period    (period),
      .sh_p1wid  (sh_p1wid),
      .sh_del    (sh_del),
      .sh_p2wid  (sh_p2wid),
      .sh_pr_att (sh_pr_att),
      .sh_cp     (sh_cp),
      .sh_p_bl   (sh_p_bl),
      .sh_bl     (sh_bl),
      .sh_phsub  (sh_phsub),
      .sdown     (sdown),
      .nut_start (nut_start),
      .nut_stop  (nut_stop)
   );

   // execute, frame counter and pi pulse train
   train_engine train_engine_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .mode            (mode),
      .period          (period),
      .p1wid           (sh_p1wid),
      .del             (sh_del),
      .p2wid           (sh_p2wid),
      .p_bl            (sh_p_bl),
      .cp              (sh_cp),
      .counter         (counter),
      .frame_end       (frame_end),
      .in_excite       (in_excite),
      .in_refocus      (in_refocus),
      .in_window       (in_window),
      .train_active    (train_active),
      .first_ref_start (first_ref_start)
   );

   // result, registered switch and phase outputs
   gate_drive gate_drive_inst (
      .clk             (clk),
      .rst_n           (rst_n),
      .mode            (mode),
      .counter         (counter),
      .period          (period),
      .in_excite       (in_excite),
      .in_refocus      (in_refocus),
      .in_window       (in_window),
      .train_active    (train_active),
      .first_ref_start (first_ref_start),
      .sdown           (sdown),
      .nut_start       (nut_start),
      .nut_stop        (nut_stop),
      .pr_att          (sh_pr_att),
      .bl              (sh_bl),
      .phsub           (sh_phsub),
      .sync_on         (sync_on),
      .pulse1_on       (pulse1_on),
      .pulse2_on       (pulse2_on),
      .pre_att         (pre_att),
      .pre_block       (pre_block),
      .phase90         (phase90),
      .phase180        (phase180),
      .inhib           (inhib)
   );

endmodule

`default_nettype wire

//--- design/seq_config.sv
`timescale 1ns/1ns
`default_nettype none

module seq_config (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              frame_end,   // counter at shadow period
   input  logic [pulse_pkg::time_w-1:0]      per,
   input  logic [pulse_pkg::short_w-1:0]     p1wid,
   input  logic [pulse_pkg::short_w-1:0]     del,
   input  logic [pulse_pkg::short_w-1:0]     p2wid,
   input  logic [pulse_pkg::short_w-1:0]     nut_w,
   input  logic [pulse_pkg::short_w-1:0]     nut_d,
   input  logic [pulse_pkg::att_w-1:0]       pr_att,
   input  logic [pulse_pkg::count_w-1:0]     cp,
   input  logic [pulse_pkg::short_w-1:0]     p_bl,
   input  logic                              bl,
   input  logic [2:0]                        phsub,
   output pulse_pkg::seq_mode_e              mode,
   output logic [pulse_pkg::time_w-1:0]      period,
   output logic [pulse_pkg::short_w-1:0]     sh_p1wid,
   output logic [pulse_pkg::short_w-1:0]     sh_del,
   output logic [pulse_pkg::short_w-1:0]     sh_p2wid,
   output logic [pulse_pkg::att_w-1:0]       sh_pr_att,
   output logic [pulse_pkg::count_w-1:0]     sh_cp,
   output logic [pulse_pkg::short_w-1:0]     sh_p_bl,
   output logic                              sh_bl,
   output logic [2:0]                        sh_phsub,
   output logic [pulse_pkg::time_w-1:0]      sdown,       // end of first pi pulse
   output logic [pulse_pkg::time_w-1:0]      nut_start,
   output logic [pulse_pkg::time_w-1:0]      nut_stop
);

   import pulse_pkg::*;

   // shadow copies hold for a whole frame
   // reset keeps reloading so the first frame starts with live settings
   always_ff @(posedge clk) begin
      if (!rst_n || frame_end) begin
         period    <= per;
         sh_p1wid  <= p1wid;
         sh_del    <= del;
         sh_p2wid  <= p2wid;
         sh_pr_att <= pr_att;
         sh_cp     <= cp;
         sh_p_bl   <= p_bl;
         sh_bl     <= bl;
         sh_phsub  <= phsub;

         // markers straight from the inputs, same edge as the shadows
         sdown     <= time_w'(p1wid) + time_w'(del) + time_w'(p2wid);
         nut_start <= per - time_w'(nut_d) - time_w'(nut_w);  // zero width gives no pulse
         nut_stop  <= per - time_w'(nut_d);

         case (cp)
            count_w'(0): mode <= mode_cw;
            count_w'(1): mode <= mode_hahn;   // one pi pulse
            default:     mode <= mode_cpmg;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/train_engine.sv
`timescale 1ns/1ns
`default_nettype none

module train_engine (
   input  logic                              clk,
   input  logic                              rst_n,
   input  pulse_pkg::seq_mode_e              mode,
   input  logic [pulse_pkg::time_w-1:0]      period,
   input  logic [pulse_pkg::short_w-1:0]     p1wid,
   input  logic [pulse_pkg::short_w-1:0]     del,
   input  logic [pulse_pkg::short_w-1:0]     p2wid,
   input  logic [pulse_pkg::short_w-1:0]     p_bl,
   input  logic [pulse_pkg::count_w-1:0]     cp,
   output logic [pulse_pkg::time_w-1:0]      counter,
   output logic                              frame_end,
   output logic                              in_excite,
   output logic                              in_refocus,
   output logic                              in_window,
   output logic                              train_active,
   output logic [pulse_pkg::time_w-1:0]      first_ref_start
);

   import pulse_pkg::*;

   train_state_e       state;
   logic [count_w-1:0] idx;          // current pi pulse, 0 before the first
   logic [time_w-1:0]  mk_start;     // current pi pulse start
   logic [time_w-1:0]  mk_end;       // current pi pulse end
   logic [time_w-1:0]  win_open;     // echo window opens here
   logic [time_w-1:0]  win_close;    // next pulse start, window shuts window_trim before it
   logic [time_w-1:0]  gap;          // two del between pulse end and next start
   logic [time_w-1:0]  first_end;
   logic               pulsed;
   logic               load_first;
   logic               advance;
   logic               load_next;

   assign pulsed          = (mode != mode_cw);
   assign gap             = time_w'(del) + time_w'(del);
   assign first_ref_start = time_w'(p1wid) + time_w'(del);
   assign first_end       = first_ref_start + time_w'(p2wid);

   assign frame_end = (counter == period);

   // look one cycle ahead so new markers are in place when the counter gets there
   assign load_first = (state == st_excite) && pulsed && (counter + 1 >= first_ref_start);
   assign advance    = (state == st_refocus || state == st_free) && (counter + 1 >= win_close);
   assign load_next  = advance && (idx < cp);

   assign in_excite  = (counter < time_w'(p1wid));
   assign in_refocus = pulsed && (state == st_refocus) && (p2wid != '0) &&
                       (counter >= mk_start) && (counter < mk_end);   // p2wid 0 emits nothing
   assign in_window  = pulsed && (state == st_refocus || state == st_free) &&
                       (counter >= win_open) &&
                       (counter + time_w'(window_trim) < win_close);    // empty if open >= close
   // high until the last pi pulse ends
   assign train_active = pulsed && (state != st_done) && (idx < cp || counter < mk_end);

   // frame counter and train FSM
   always_ff @(posedge clk) begin
      if (!rst_n || frame_end) begin
         counter <= '0;          // wrap from period to zero
         state   <= st_excite;
         idx     <= '0;
      end else begin
         counter <= counter + time_w'(1);
         case (state)
            st_excite: begin
               if (!pulsed) begin
                  state <= st_done;   // CW, nothing to track
               end else if (load_first) begin
                  state <= st_refocus;
                  idx   <= count_w'(1);
               end
            end
            st_refocus, st_free: begin
               if (advance) begin
                  if (load_next) begin
                     state <= st_refocus;
                     idx   <= idx + count_w'(1);
                  end else begin
                     state <= st_done;   // last echo over
                  end
               end else if (counter + 1 >= mk_end) begin
                  state <= st_free;
               end
            end
            default: state <= st_done;
         endcase
      end
   end

   // pulse and window markers, like cdelay/cpulse stepping by 2*del + p2wid
   always_ff @(posedge clk) begin
      if (load_first) begin
         mk_start  <= first_ref_start;
         mk_end    <= first_end;
         win_open  <= first_end + time_w'(p_bl);
         win_close <= first_end + gap;
      end else if (load_next) begin
         mk_start  <= win_close;
         mk_end    <= win_close + time_w'(p2wid);
         win_open  <= win_close + time_w'(p2wid) + time_w'(p_bl);
         win_close <= win_close + time_w'(p2wid) + gap;
      end
   end

   a_idx_max : assert property (@(posedge clk) disable iff (!rst_n) idx <= cp);
   a_cnt_max : assert property (@(posedge clk) disable iff (!rst_n) counter <= period);
   // window always sits between pulses
   a_win_ref : assert property (@(posedge clk) disable iff (!rst_n)
                                !(in_window && in_refocus));

endmodule

`default_nettype wire

//--- pulse_seq_top.f
design/pulse_pkg.sv
design/seq_config.sv
design/train_engine.sv
design/gate_drive.sv
design/pulse_seq_top.sv
tests/seq_checker.sv
tests/tb_pulse_seq.sv

//--- tests/seq_checker.sv
`timescale 1ns/1ns
`default_nettype none

module seq_checker (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic [pulse_pkg::time_w-1:0]      per,
   input  logic [pulse_pkg::short_w-1:0]     p1wid,
   input  logic [pulse_pkg::short_w-1:0]     del,
   input  logic [pulse_pkg::short_w-1:0]     p2wid,
   input  logic [pulse_pkg::short_w-1:0]     nut_w,
   input  logic [pulse_pkg::short_w-1:0]     nut_d,
   input  logic [pulse_pkg::att_w-1:0]       pr_att,
   input  logic [pulse_pkg::count_w-1:0]     cp,
   input  logic [pulse_pkg::short_w-1:0]     p_bl,
   input  logic                              bl,
   input  logic [2:0]                        phsub,
   input  logic                              sync_on,
   input  logic                              pulse1_on,
   input  logic                              pulse2_on,
   input  logic [pulse_pkg::att_w-1:0]       pre_att,
   input  logic                              pre_block,
   input  logic                              phase90,
   input  logic                              phase180,
   input  logic                              inhib,
   output int                                err_count,
   output int                                check_count,
   output int                                frame_cnt     // completed model frames
);

   import pulse_pkg::*;

   int               s_per;    // model shadows, one frame each
   int               s_p1;
   int               s_del;
   int               s_p2;
   int               s_nw;
   int               s_nd;
   int               s_cp;
   int               s_pbl;
   logic [att_w-1:0] s_att;
   logic             s_bl;
   logic [2:0]       s_ph;
   int               cnt;      // own frame counter
   logic             armed;    // outputs defined once reset has been seen
   logic             e_sync;   // expected outputs, registered like the DUT
   logic             e_p1;
   logic             e_p2;
   logic [att_w-1:0] e_att;
   logic             e_blk;
   logic             e_p90;
   logic             e_p180;
   logic             e_inh;

   task automatic load_shadows();
      s_per = int'(per);
      s_p1  = int'(p1wid);
      s_del = int'(del);
      s_p2  = int'(p2wid);
      s_nw  = int'(nut_w);
      s_nd  = int'(nut_d);
      s_cp  = int'(cp);
      s_pbl = int'(p_bl);
      s_att = pr_att;
      s_bl  = bl;
      s_ph  = phsub;
   endtask

   task automatic compare_output(input string sig, input logic [7:0] exp_v,
                                 input logic [7:0] act_v);
      check_count++;
      if (act_v !== exp_v) begin
         err_count++;
         $display("MISMATCH time=%0t %s expected=%0h actual=%0h", $time, sig, exp_v, act_v);
      end
   endtask

   // pi pulse i starts at p1 + (2i-1)*del + (i-1)*p2 and lasts p2
   function automatic logic refocus_on(input int c);
      int i;
      int s;
      refocus_on = 1'b0;
      for (i = 1; i <= s_cp; i++) begin
         s = s_p1 + (2 * i - 1) * s_del + (i - 1) * s_p2;
         if (c >= s && c < s + s_p2) refocus_on = 1'b1;
      end
   endfunction

   // echo window from pulse end + p_bl up to pulse end + 2 del - trim
   function automatic logic window_on(input int c);
      int i;
      int e;
      window_on = 1'b0;
      for (i = 1; i <= s_cp; i++) begin
         e = s_p1 + (2 * i - 1) * s_del + i * s_p2;
         if (c >= e + s_pbl && c < e + 2 * s_del - window_trim) window_on = 1'b1;
      end
   endfunction

   initial begin
      err_count   = 0;
      check_count = 0;
      frame_cnt   = 0;
      armed       = 1'b0;
   end

   // outputs are read before their NBA update, so this edge sees last edge's values
   always @(posedge clk) begin
      logic pulsed;
      logic excite;
      logic tail;
      logic mid;
      int   train_end;
      if (armed) begin
         compare_output("sync_on", e_sync, sync_on);
         compare_output("pulse1_on", e_p1, pulse1_on);
         compare_output("pulse2_on", e_p2, pulse2_on);
         compare_output("pre_att", e_att, pre_att);
         compare_output("pre_block", e_blk, pre_block);
         compare_output("phase90", e_p90, phase90);
         compare_output("phase180", e_p180, phase180);
         compare_output("inhib", e_inh, inhib);
      end
      if (!rst_n) begin
         load_shadows();
         cnt    = 0;
         armed  = 1'b1;
         e_sync = 1'b0;
         e_p1   = 1'b0;
         e_p2   = 1'b0;
         e_att  = '0;
         e_blk  = 1'b0;
         e_p90  = 1'b0;
         e_p180 = 1'b0;
         e_inh  = 1'b0;
      end else begin
         pulsed    = (s_cp != 0);
         excite    = (cnt < s_p1);
         tail      = (cnt >= s_per - tail_len);
         mid       = (cnt >= s_p1 + s_del - phase_lead) && !tail;
         train_end = s_p1 + (2 * s_cp - 1) * s_del + s_cp * s_p2;   // last pi pulse end
         if (!pulsed) begin
            e_p1   = !s_bl;   // cw
            e_p2   = s_bl;
            e_inh  = 1'b0;
            e_blk  = 1'b1;
            e_att  = s_att;
            e_sync = (cnt >= s_p1 + s_del + s_p2);
            e_p90  = s_ph[1];
            e_p180 = s_ph[2];
         end else begin
            e_blk  = e_p1 || e_p2;   // uses the switch values still on the pins
            e_p1   = excite || refocus_on(cnt);
            e_p2   = (cnt >= s_per - s_nd - s_nw) && (cnt < s_per - s_nd);
            e_inh  = s_bl && !window_on(cnt);
            e_sync = (cnt < train_end);
            e_att  = (excite || tail) ? s_att + att_w'(att_step) : s_att;
            e_p90  = (s_ph != 3'd0) && mid;
            if (s_ph == 3'd0) e_p180 = 1'b0;
            else e_p180 = mid ? s_ph[2] : (s_ph[2] ^ s_ph[1]);
         end
         if (cnt == s_per) begin   // frame wrap, next frame takes new settings
            load_shadows();
            cnt = 0;
            frame_cnt++;
         end else begin
            cnt++;
         end
      end
   end

endmodule

`default_nettype wire

//--- tests/tb_pulse_seq.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pulse_seq;

   import pulse_pkg::*;

   logic               clk;
   logic               rst_n;
   logic [time_w-1:0]  per;
   logic [short_w-1:0] p1wid;
   logic [short_w-1:0] del;
   logic [short_w-1:0] p2wid;
   logic [short_w-1:0] nut_w;
   logic [short_w-1:0] nut_d;
   logic [att_w-1:0]   pr_att;
   logic [count_w-1:0] cp;
   logic [short_w-1:0] p_bl;
   logic               bl;
   logic [2:0]         phsub;
   logic               sync_on;
   logic               pulse1_on;
   logic               pulse2_on;
   logic [att_w-1:0]   pre_att;
   logic               pre_block;
   logic               phase90;
   logic               phase180;
   logic               inhib;
   int                 err_count;
   int                 check_count;
   int                 frame_cnt;
   int                 seed;
   int                 fail_tests;

   pulse_seq_top pulse_seq_top_inst (.*);

   seq_checker seq_checker_inst (.*);   // reference model and compare

   always #4 clk = ~clk;   // 8 ns

   function automatic int rand_range(input int lo, input int hi);
      rand_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;   // drive just after the edge
      end
   endtask

   task automatic wait_frames(input int n);
      int target;
      int waited;
      target = frame_cnt + n;
      waited = 0;
      while (frame_cnt < target && waited < n * 1500) begin
         idle_cycles(1);
         waited++;
      end
      if (frame_cnt < target) begin
         $display("Timeout: no frame boundary seen within %0d cycles", waited);
         $display("Regression failed");
         $finish;
      end
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      idle_cycles(4);
      rst_n = 1'b1;
   endtask

   // kind picks the mode under test, k the iteration inside it
   task automatic draw_settings(input int kind, input int k);
      per    = time_w'(rand_range(200, 600));
      p1wid  = short_w'(rand_range(0, 15));
      del    = short_w'(rand_range(5, 30));
      p2wid  = short_w'(rand_range(0, 15));
      nut_w  = short_w'(rand_range(0, 15));
      nut_d  = short_w'(rand_range(0, 15));
      pr_att = att_w'(rand_range(0, 127));
      p_bl   = short_w'(rand_range(0, 15));
      bl     = rand_range(0, 1) != 0;
      phsub  = 3'(rand_range(0, 7));
      cp     = count_w'(rand_range(0, 4));
      case (kind)
         1: begin
            cp = '0;   // cw
            bl = k[0];
         end
         2: begin
            cp = count_w'(1);
            bl = 1'b1;
         end
         3: begin
            cp = count_w'(rand_range(2, 4));
            bl = 1'b1;
            if (k == 1) p2wid = '0;   // windows but no pi pulses
            if (k == 2) begin
               del  = short_w'(5);    // window closes before it opens
               p_bl = short_w'(10);
            end
         end
         4: if (k == 1) nut_w = '0;
         5: phsub = 3'(k);
         default: ;
      endcase
   endtask

   task automatic run_test(input string name, input int kind);
      int errs0;
      int iters;
      errs0 = err_count;
      iters = (kind == 5) ? 8 : 4;
      for (int k = 0; k < iters; k++) begin
         idle_cycles(rand_range(1, 150));   // land somewhere inside a frame
         draw_settings(kind, k);
         if (kind == 6) begin
            idle_cycles(rand_range(1, 50));   // second change in the same frame
            draw_settings(kind, k);
            if (k == iters - 1) apply_reset();
         end
         wait_frames(2);
      end
      if (err_count == errs0) begin
         $display("test %-10s ok, %0d checks so far", name, check_count);
      end else begin
         fail_tests++;
         $display("test %-10s FAIL, %0d mismatches", name, err_count - errs0);
      end
   endtask

   initial begin
      seed       = 50589;
      fail_tests = 0;
      clk        = 1'b0;
      rst_n      = 1'b0;
      per        = time_w'(300);
      p1wid      = short_w'(4);
      del        = short_w'(10);
      p2wid      = short_w'(8);
      nut_w      = '0;
      nut_d      = '0;
      pr_att     = '0;
      cp         = '0;
      p_bl       = '0;
      bl         = 1'b0;
      phsub      = 3'd0;
      idle_cycles(4);
      rst_n = 1'b1;
      run_test("cw", 1);
      run_test("hahn", 2);
      run_test("cpmg", 3);
      run_test("nut_att", 4);
      run_test("phase", 5);
      run_test("midframe", 6);
      $display("summary: 6 tests, %0d failing, %0d checks, %0d mismatches",
               fail_tests, check_count, err_count);
      if (fail_tests == 0 && err_count == 0 && check_count > 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
